/* build.f */
source/video_pkg.sv
source/video_timing.sv
source/video_mmr.sv
source/video_layer.sv
source/video_colmix.sv
source/video_pal.sv
source/video_top.sv
sim/tb_video.sv

/* run_sim.sh */
#!/bin/sh
# Compile the testbench with Verilator, run it, and decide the result
# from the simulation output. Run from the project root.

verilator --binary -j 0 --top-module tb_video -f build.f -o tb_video \
    && ./obj_dir/tb_video | tee /dev/stderr | grep -q "Test completed successfully" \
    && echo "run_sim: PASS" \
    || { echo "run_sim: FAIL"; exit 1; }

/* sim/tb_video.sv */
/*
 * Testbench for the tile video subsystem. Fills the external tile map and
 * graphics memories at random, programs registers and palette through the
 * CPU port, and checks raster timing, readback and every output pixel
 * against a reference model built from the layer, mixer and palette rules.
 */
`timescale 1ns/10ps

module tb_video;

    localparam int clk_period  = 40;
    localparam int frame_ticks = int'(video_pkg::h_total) * int'(video_pkg::v_total);
    // Frames spent waiting for vblank, checking, and switching layer modes
    localparam int test_frames = 7;
    localparam int setup_ns    = (16 + 64 * 8 + 512 * 2 + 256) * clk_period;
    localparam int watchdog_ns = (test_frames + 1) * frame_ticks * 2 * clk_period + setup_ns;

    typedef struct packed {
        logic [8:0]      h;
        logic [8:0]      v;
        video_pkg::rgb_t rgb;
        logic            lhbl;
        logic            lvbl;
    } expect_t;

    logic                  clk;
    logic                  rst;
    logic                  pxl_cen;
    video_pkg::cpu_write_t cpu;
    logic [15:0]           mmr_dout;
    logic [15:0]           map1_addr;
    logic [15:0]           map1_data;
    logic [19:0]           gfx1_addr;
    logic [15:0]           gfx1_data;
    logic [15:0]           map2_addr;
    logic [15:0]           map2_data;
    logic [19:0]           gfx2_addr;
    logic [15:0]           gfx2_data;
    logic [8:0]            hdump;
    logic [8:0]            vdump;
    logic                  hsync;
    logic                  vsync;
    logic                  lhbl;
    logic                  lvbl;
    video_pkg::rgb_t       rgb;

    logic [15:0] map1_mem [65536];
    logic [15:0] map2_mem [65536];
    logic [15:0] gfx1_mem [65536];
    logic [15:0] gfx2_mem [262144];
    logic [15:0] reg_shadow [8];
    logic [15:0] pal_shadow [512];
    expect_t     exp_q [$];
    int          seed = 31479;
    logic        pixel_check = 1'b0;
    int          pixel_count = 0;

    // External memories answer in the same cycle
    assign map1_data = map1_mem[map1_addr];
    assign map2_data = map2_mem[map2_addr];
    assign gfx1_data = gfx1_mem[gfx1_addr[15:0]];
    assign gfx2_data = gfx2_mem[gfx2_addr[17:0]];

    video_top i_dut (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .pxl_cen   ( pxl_cen   ),
        .cpu       ( cpu       ),
        .mmr_dout  ( mmr_dout  ),
        .map1_addr ( map1_addr ),
        .map1_data ( map1_data ),
        .gfx1_addr ( gfx1_addr ),
        .gfx1_data ( gfx1_data ),
        .map2_addr ( map2_addr ),
        .map2_data ( map2_data ),
        .gfx2_addr ( gfx2_addr ),
        .gfx2_data ( gfx2_data ),
        .hdump     ( hdump     ),
        .vdump     ( vdump     ),
        .hsync     ( hsync     ),
        .vsync     ( vsync     ),
        .lhbl      ( lhbl      ),
        .lvbl      ( lvbl      ),
        .rgb       ( rgb       )
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // Pixel enable on every second clock once out of reset
    initial begin : pixel_enable
        pxl_cen <= 1'b0;
        forever begin
            @(posedge clk);
            pxl_cen <= !rst && !pxl_cen;
        end
    end

    initial begin : watchdog
        #(watchdog_ns);
        $display("Watchdog expired before all frames were checked");
        $display("Test failed");
        $fatal(1, "simulation timeout");
    end

    task automatic check_rgb(input string name, input video_pkg::rgb_t expected,
                             input video_pkg::rgb_t actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            $display("Test failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic check_word(input string name, input logic [15:0] expected,
                              input logic [15:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            $display("Test failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic check_raster(input string name, input video_pkg::raster_t expected,
                                input video_pkg::raster_t actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            $display("Test failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    function automatic logic [15:0] merge_bytes(input logic [15:0] old, input logic [15:0] data,
                                                input logic [1:0] be_n);
        return {be_n[1] ? old[15:8] : data[15:8], be_n[0] ? old[7:0] : data[7:0]};
    endfunction

    // Pixel of one layer at a screen position, from the addressing rules
    function automatic video_pkg::layer_pxl_t lookup_layer(input int tsize, input logic second,
            input logic [8:0] h, input logic [8:0] v, input logic [15:0] hpos,
            input logic [15:0] vpos, input logic [15:0] base);
        logic [15:0]           x;
        logic [15:0]           y;
        logic [15:0]           maddr;
        logic [15:0]           mword;
        logic [17:0]           gaddr;
        logic [15:0]           gword;
        int                    shift;
        video_pkg::layer_pxl_t p;
        x = {7'd0, h} + hpos;
        y = {7'd0, v} + vpos;
        maddr = base + 16'(int'(y) / tsize % 64 * 64 + int'(x) / tsize % 64);
        mword = second ? map2_mem[maddr] : map1_mem[maddr];
        gaddr = 18'(int'(mword[11:0]) * (tsize * tsize / 4) + int'(y) % tsize * (tsize / 4)
                    + int'(x) % tsize / 4);
        gword = second ? gfx2_mem[gaddr] : gfx1_mem[gaddr[15:0]];
        shift = 12 - 4 * (int'(x) % 4);
        p.group  = mword[15:12];
        p.color  = 4'(gword >> shift);
        p.opaque = p.color != video_pkg::transparent_pen;
        return p;
    endfunction

    function automatic expect_t expect_pixel(input logic [8:0] h, input logic [8:0] v);
        video_pkg::layer_pxl_t p1;
        video_pkg::layer_pxl_t p2;
        logic [15:0]           ctrl;
        logic                  vis1;
        logic                  vis2;
        logic [8:0]            idx;
        logic [15:0]           entry;
        expect_t               e;
        ctrl = reg_shadow[video_pkg::reg_layer_ctrl];
        p1 = lookup_layer(8, 1'b0, h, v, reg_shadow[video_pkg::reg_hpos1],
                          reg_shadow[video_pkg::reg_vpos1], reg_shadow[video_pkg::reg_map1_base]);
        p2 = lookup_layer(16, 1'b1, h, v, reg_shadow[video_pkg::reg_hpos2],
                          reg_shadow[video_pkg::reg_vpos2], reg_shadow[video_pkg::reg_map2_base]);
        vis1 = ctrl[0] && p1.opaque;
        vis2 = ctrl[1] && p2.opaque;
        idx = reg_shadow[video_pkg::reg_backdrop][8:0];
        if (vis2 && (ctrl[2] || !vis1)) begin
            idx = {1'b1, p2.group, p2.color};
        end else if (vis1) begin
            idx = {1'b0, p1.group, p1.color};
        end
        entry  = pal_shadow[idx];
        e.h    = h;
        e.v    = v;
        e.lhbl = h < video_pkg::h_visible;
        e.lvbl = v < video_pkg::v_visible;
        e.rgb  = '0;
        if (e.lhbl && e.lvbl) begin
            // 4-bit to 8-bit by nibble repeat, i.e. times 17
            e.rgb.red   = 8'(entry[11:8]) * 8'd17;
            e.rgb.green = 8'(entry[7:4]) * 8'd17;
            e.rgb.blue  = 8'(entry[3:0]) * 8'd17;
        end
        return e;
    endfunction

    // Returns at the falling edge after a clock edge with pxl_cen high
    task automatic wait_tick();
        logic seen;
        seen = 1'b0;
        while (!seen) begin
            @(posedge clk);
            seen = pxl_cen;
        end
        @(negedge clk);
    endtask

    task automatic wait_line(input logic [8:0] line);
        logic found;
        found = 1'b0;
        while (!found) begin
            wait_tick();
            found = vdump == line && hdump == 9'd0;
        end
    endtask

    task automatic cpu_write(input logic sel, input logic [8:0] addr, input logic [1:0] be_n,
                             input logic [15:0] data);
        video_pkg::cpu_write_t wr;
        wr.we     = 1'b1;
        wr.region = sel;
        wr.addr   = addr;
        wr.be_n   = be_n;
        wr.data   = data;
        @(posedge clk);
        cpu <= wr;
        @(posedge clk);
        cpu.we <= 1'b0;
        if (sel == video_pkg::region_pal) begin
            pal_shadow[addr] = merge_bytes(pal_shadow[addr], data, be_n);
        end else if (addr < 9'd8) begin
            reg_shadow[addr[2:0]] = merge_bytes(reg_shadow[addr[2:0]], data, be_n);
        end
    endtask

    task automatic check_register(input logic [2:0] index);
        video_pkg::cpu_write_t rd;
        rd        = '0;
        rd.region = video_pkg::region_reg;
        rd.addr   = {6'd0, index};
        rd.be_n   = 2'b11;
        @(posedge clk);
        cpu <= rd;
        @(negedge clk);
        check_word($sformatf("register %0d readback", index), reg_shadow[index], mmr_dout);
    endtask

    task automatic fill_memories();
        for (int i = 0; i < 65536; i++) begin
            map1_mem[16'(i)] = 16'($random(seed));
            map2_mem[16'(i)] = 16'($random(seed));
            gfx1_mem[16'(i)] = 16'($random(seed));
        end
        for (int i = 0; i < 262144; i++) begin
            gfx2_mem[18'(i)] = 16'($random(seed));
        end
        for (int i = 0; i < 512; i++) begin
            pal_shadow[9'(i)] = 16'd0;
        end
        for (int i = 0; i < 8; i++) begin
            reg_shadow[3'(i)] = 16'd0;
        end
    endtask

    task automatic register_test();
        logic [2:0] index;
        for (int n = 0; n < 64; n++) begin
            index = 3'($random(seed));
            cpu_write(video_pkg::region_reg, {6'd0, index}, 2'($random(seed)),
                      16'($random(seed)));
            check_register(index);
        end
        for (int i = 0; i < 8; i++) begin
            check_register(3'(i));
        end
    endtask

    task automatic load_display();
        for (int i = 0; i < 512; i++) begin
            cpu_write(video_pkg::region_pal, 9'(i), 2'b00, 16'($random(seed)));
        end
        cpu_write(video_pkg::region_reg, {6'd0, video_pkg::reg_hpos1}, 2'b00, 16'($random(seed)));
        cpu_write(video_pkg::region_reg, {6'd0, video_pkg::reg_vpos1}, 2'b00, 16'($random(seed)));
        cpu_write(video_pkg::region_reg, {6'd0, video_pkg::reg_hpos2}, 2'b00, 16'($random(seed)));
        cpu_write(video_pkg::region_reg, {6'd0, video_pkg::reg_vpos2}, 2'b00, 16'($random(seed)));
        cpu_write(video_pkg::region_reg, {6'd0, video_pkg::reg_map1_base}, 2'b00,
                  16'($random(seed)));
        cpu_write(video_pkg::region_reg, {6'd0, video_pkg::reg_map2_base}, 2'b00,
                  16'($random(seed)));
        cpu_write(video_pkg::region_reg, {6'd0, video_pkg::reg_layer_ctrl}, 2'b00, 16'h0003);
        cpu_write(video_pkg::region_reg, {6'd0, video_pkg::reg_backdrop}, 2'b00,
                  16'($random(seed)));
        // Registers hold only register writes, palette traffic aside
        for (int i = 0; i < 8; i++) begin
            check_register(3'(i));
        end
    endtask

    // Runs every tick: raster model, then the delayed pixel comparison
    initial begin : monitor
        logic [8:0]         mh;
        logic [8:0]         mv;
        logic [1:0]         sync_exp;
        video_pkg::raster_t ras;
        video_pkg::raster_t act;
        expect_t            e;
        string              where;
        mh = 9'd0;
        mv = 9'd0;
        @(negedge rst);
        forever begin
            wait_tick();
            if (mh == video_pkg::h_total - 9'd1) begin
                mh = 9'd0;
                mv = (mv == video_pkg::v_total - 9'd1) ? 9'd0 : mv + 9'd1;
            end else begin
                mh = mh + 9'd1;
            end
            ras.hdump  = mh;
            ras.vdump  = mv;
            ras.hblank = mh >= video_pkg::h_visible;
            ras.vblank = mv >= video_pkg::v_visible;
            act.hdump  = hdump;
            act.vdump  = vdump;
            act.hblank = i_dut.raster.hblank;
            act.vblank = i_dut.raster.vblank;
            check_raster("raster counters", ras, act);
            sync_exp[1] = mh >= video_pkg::hs_start && mh < video_pkg::hs_end;
            sync_exp[0] = mv >= video_pkg::vs_start && mv < video_pkg::vs_end;
            check_word("sync flags", {14'd0, sync_exp}, {14'd0, hsync, vsync});

            exp_q.push_back(expect_pixel(mh, mv));
            if (exp_q.size() > video_pkg::pipe_ticks) begin
                e = exp_q.pop_front();
                where = $sformatf("h=%0d v=%0d", e.h, e.v);
                check_word({"valid flags at ", where}, {14'd0, e.lhbl, e.lvbl},
                           {14'd0, lhbl, lvbl});
                // Blanked pixels must be black whatever the registers hold
                if (pixel_check || !(e.lhbl && e.lvbl)) begin
                    check_rgb({"rgb at ", where}, e.rgb, rgb);
                    pixel_count++;
                end
            end
        end
    end

    initial begin : main
        logic [2:0] modes [4];
        modes = '{3'b111, 3'b001, 3'b010, 3'b000};
        rst <= 1'b1;
        cpu <= '0;
        fill_memories();
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_rgb("rgb after reset", '0, rgb);
        check_word("valid and sync after reset", 16'd0, {12'd0, lhbl, lvbl, hsync, vsync});
        check_raster("raster after reset", '0, i_dut.raster);

        register_test();

        // Registers and palette change only inside vblank
        wait_line(video_pkg::v_visible + 9'd1);
        load_display();
        pixel_check = 1'b1;
        wait_line(video_pkg::v_visible + 9'd1);
        wait_line(video_pkg::v_visible + 9'd1);

        // Priority swap, single layers, then backdrop only
        foreach (modes[m]) begin
            cpu_write(video_pkg::region_reg, {6'd0, video_pkg::reg_layer_ctrl}, 2'b00,
                      {13'd0, modes[m]});
            cpu_write(video_pkg::region_reg, {6'd0, video_pkg::reg_backdrop}, 2'b00,
                      16'($random(seed)));
            wait_line(video_pkg::v_visible + 9'd1);
        end

        $display("Checked %0d pixels", pixel_count);
        $display("Test completed successfully");
        $finish;
    end

endmodule

/* source/video_colmix.sv */
/*
 * Priority mixer. Picks the top visible layer pixel, or the
 * backdrop when neither layer shows, and registers the result
 * as a 9-bit palette index one tick later.
 */
`timescale 1ns/10ps

module video_colmix (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     pxl_cen,
    input  video_pkg::layer_pxl_t    layer1,
    input  video_pkg::layer_pxl_t    layer2,
    input  video_pkg::layer_ctrl_t   layer_ctrl,
    output logic [8:0]               pal_index
);

    logic       l1_vis;
    logic       l2_vis;
    logic [8:0] l1_index;
    logic [8:0] l2_index;
    logic [8:0] mix_index;

    assign l1_vis = layer_ctrl.layer1_en && layer1.opaque;
    assign l2_vis = layer_ctrl.layer2_en && layer2.opaque;

    // Top bit of the index selects the layer's half of the palette
    assign l1_index = {1'b0, layer1.group, layer1.color};
    assign l2_index = {1'b1, layer2.group, layer2.color};

    always_comb begin
        mix_index = layer_ctrl.backdrop;
        if (layer_ctrl.layer2_on_top) begin
            if (l2_vis) begin
                mix_index = l2_index;
            end else if (l1_vis) begin
                mix_index = l1_index;
            end
        end else begin
            if (l1_vis) begin
                mix_index = l1_index;
            end else if (l2_vis) begin
                mix_index = l2_index;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pal_index <= 9'd0;
        end else if (pxl_cen) begin
            pal_index <= mix_index;
        end
    end

endmodule

/* source/video_layer.sv */
/*
 * One scroll layer. Maps the raster position through the scroll
 * offset to a tile map word, then to a graphics word, then to a
 * 4-bit pen. Three pixel-enable ticks from position to pixel.
 * tile_size selects 8x8 or 16x16 tiles on a 64x64 map.
 */
`timescale 1ns/10ps

module video_layer #(
    parameter int tile_size = 8
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    pxl_cen,
    input  video_pkg::raster_t      raster,
    input  video_pkg::scroll_t      scroll,
    output logic [15:0]             map_addr,
    input  logic [15:0]             map_data,
    output logic [19:0]             gfx_addr,
    input  logic [15:0]             gfx_data,
    output video_pkg::layer_pxl_t   pxl
);

    localparam int tile_bits = $clog2(tile_size);
    // Graphics words per tile row, as a bit count
    localparam int word_bits = tile_bits - 2;

    logic [15:0]                     x;
    logic [15:0]                     y;
    logic [11:0]                     map_index;
    logic [11+tile_bits+word_bits:0] tile_word;

    logic [tile_bits-1:0] xf1;
    logic [tile_bits-1:0] yf1;
    logic [3:0]           group2;
    logic [1:0]           xs2;
    logic [3:0]           pen;

    always_comb begin
        x = {7'd0, raster.hdump} + scroll.hpos;
        y = {7'd0, raster.vdump} + scroll.vpos;
        // Row and column wrap at 64 tiles
        map_index = {y[tile_bits+5:tile_bits], x[tile_bits+5:tile_bits]};
    end

    // Tile code, fine row, then word within the row
    assign tile_word = {map_data[11:0], yf1, xf1[tile_bits-1:2]};

    // Leftmost pixel sits in the top nibble
    assign pen = gfx_data[{~xs2, 2'b11} -: 4];

    // Map lookup stage, then graphics lookup stage
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            map_addr <= scroll.map_base + {4'd0, map_index};
            xf1      <= x[tile_bits-1:0];
            yf1      <= y[tile_bits-1:0];

            gfx_addr <= 20'(tile_word);
            group2   <= map_data[15:12];
            xs2      <= xf1[1:0];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pxl <= '0;
        end else if (pxl_cen) begin
            pxl.group  <= group2;
            pxl.color  <= pen;
            pxl.opaque <= pen != video_pkg::transparent_pen;
        end
    end

endmodule

/* source/video_mmr.sv */
/*
 * CPU register block. Eight 16-bit words with active-low byte enables,
 * combinational readback, and decode into the scroll and layer
 * control structs used by the pixel datapath.
 */
`timescale 1ns/10ps

module video_mmr (
    input  logic                     clk,
    input  logic                     rst,
    input  video_pkg::cpu_write_t    cpu,
    output logic [15:0]              mmr_dout,
    output video_pkg::scroll_t       scroll1,
    output video_pkg::scroll_t       scroll2,
    output video_pkg::layer_ctrl_t   layer_ctrl
);

    logic [15:0] regs [video_pkg::reg_count];
    logic        addr_hit;
    logic        reg_we;

    // Only the lowest eight words of the space are populated
    assign addr_hit = cpu.addr[8:3] == 6'd0;
    assign reg_we   = cpu.we && cpu.region == video_pkg::region_reg && addr_hit;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < video_pkg::reg_count; i++) begin
                regs[i] <= 16'd0;
            end
        end else if (reg_we) begin
            if (!cpu.be_n[1]) begin
                regs[cpu.addr[2:0]][15:8] <= cpu.data[15:8];
            end
            if (!cpu.be_n[0]) begin
                regs[cpu.addr[2:0]][7:0] <= cpu.data[7:0];
            end
        end
    end

    // Readback ignores the strobe
    assign mmr_dout = addr_hit ? regs[cpu.addr[2:0]] : 16'd0;

    always_comb begin
        scroll1.hpos     = regs[video_pkg::reg_hpos1];
        scroll1.vpos     = regs[video_pkg::reg_vpos1];
        scroll1.map_base = regs[video_pkg::reg_map1_base];

        scroll2.hpos     = regs[video_pkg::reg_hpos2];
        scroll2.vpos     = regs[video_pkg::reg_vpos2];
        scroll2.map_base = regs[video_pkg::reg_map2_base];
    end

    // Control bits 2:0 are enables and priority, the rest are spare
    always_comb begin
        layer_ctrl.layer1_en     = regs[video_pkg::reg_layer_ctrl][0];
        layer_ctrl.layer2_en     = regs[video_pkg::reg_layer_ctrl][1];
        layer_ctrl.layer2_on_top = regs[video_pkg::reg_layer_ctrl][2];
        layer_ctrl.backdrop      = regs[video_pkg::reg_backdrop][8:0];
    end

endmodule

/* source/video_pal.sv */
/*
 * Palette stage. A 512-entry RAM of 4-bit RGB written by the CPU,
 * looked up per pixel and expanded to 8 bits per channel. Blank
 * flags are delayed to line up with the pixel pipeline.
 */
`timescale 1ns/10ps

module video_pal (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    pxl_cen,
    input  video_pkg::cpu_write_t   cpu,
    input  logic [8:0]              pal_index,
    input  logic                    hblank,
    input  logic                    vblank,
    output video_pkg::rgb_t         rgb,
    output logic                    lhbl,
    output logic                    lvbl
);

    localparam int dly = video_pkg::pipe_ticks - 1;

    logic [15:0]    pal_ram [512];
    logic [15:0]    entry;
    logic [dly-1:0] hb_sr;
    logic [dly-1:0] vb_sr;
    logic           blank;

    always_ff @(posedge clk) begin
        if (cpu.we && cpu.region == video_pkg::region_pal) begin
            if (!cpu.be_n[1]) begin
                pal_ram[cpu.addr][15:8] <= cpu.data[15:8];
            end
            if (!cpu.be_n[0]) begin
                pal_ram[cpu.addr][7:0] <= cpu.data[7:0];
            end
        end
    end

    assign entry = pal_ram[pal_index];
    assign blank = hb_sr[dly-1] || vb_sr[dly-1];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            // Start out blanked until real flags arrive
            hb_sr <= '1;
            vb_sr <= '1;
            rgb   <= '0;
            lhbl  <= 1'b0;
            lvbl  <= 1'b0;
        end else if (pxl_cen) begin
            hb_sr <= {hb_sr[dly-2:0], hblank};
            vb_sr <= {vb_sr[dly-2:0], vblank};
            lhbl  <= ~hb_sr[dly-1];
            lvbl  <= ~vb_sr[dly-1];
            if (blank) begin
                rgb <= '0;
            end else begin
                // Nibble repeat so 4'hf maps to full scale
                rgb.red   <= {entry[11:8], entry[11:8]};
                rgb.green <= {entry[7:4], entry[7:4]};
                rgb.blue  <= {entry[3:0], entry[3:0]};
            end
        end
    end

endmodule

/* source/video_pkg.sv */
/*
 * Shared constants and types for the tile video subsystem.
 * Every RTL file refers to these by scoped name, and the testbench
 * uses the same definitions for its reference model.
 */
package video_pkg;

    // Raster size in pixels and lines
    localparam logic [8:0] h_total   = 9'd384;
    localparam logic [8:0] h_visible = 9'd320;
    localparam logic [8:0] v_total   = 9'd262;
    localparam logic [8:0] v_visible = 9'd224;

    // Sync windows, start inclusive and end exclusive
    localparam logic [8:0] hs_start = 9'd336;
    localparam logic [8:0] hs_end   = 9'd368;
    localparam logic [8:0] vs_start = 9'd240;
    localparam logic [8:0] vs_end   = 9'd243;

    // CPU register space, one 16-bit word per index
    localparam int         reg_count      = 8;
    localparam logic [2:0] reg_hpos1      = 3'd0;
    localparam logic [2:0] reg_vpos1      = 3'd1;
    localparam logic [2:0] reg_hpos2      = 3'd2;
    localparam logic [2:0] reg_vpos2      = 3'd3;
    localparam logic [2:0] reg_map1_base  = 3'd4;
    localparam logic [2:0] reg_map2_base  = 3'd5;
    localparam logic [2:0] reg_layer_ctrl = 3'd6;
    localparam logic [2:0] reg_backdrop   = 3'd7;

    // CPU region select
    localparam logic region_reg = 1'b0;
    localparam logic region_pal = 1'b1;

    localparam logic [3:0] transparent_pen = 4'd15;
    // Layer 3 + mixer 1 + palette 1
    localparam int         pipe_ticks      = 5;

    typedef struct packed {
        logic        we;
        logic        region;
        logic [8:0]  addr;
        logic [1:0]  be_n;
        logic [15:0] data;
    } cpu_write_t;

    typedef struct packed {
        logic [8:0] hdump;
        logic [8:0] vdump;
        logic       hblank;
        logic       vblank;
    } raster_t;

    typedef struct packed {
        logic [15:0] hpos;
        logic [15:0] vpos;
        logic [15:0] map_base;
    } scroll_t;

    typedef struct packed {
        logic       layer1_en;
        logic       layer2_en;
        logic       layer2_on_top;
        logic [8:0] backdrop;
    } layer_ctrl_t;

    typedef struct packed {
        logic [3:0] group;
        logic [3:0] color;
        logic       opaque;
    } layer_pxl_t;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_t;

endpackage

/* source/video_timing.sv */
/*
 * Raster timing generator. Horizontal and vertical counters advance
 * on the pixel enable; blank and sync flags are registered decodes
 * of the next count, so they line up with hdump and vdump.
 */
`timescale 1ns/10ps

module video_timing (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 pxl_cen,
    output video_pkg::raster_t   raster,
    output logic                 hsync,
    output logic                 vsync
);

    logic [8:0] h_next;
    logic [8:0] v_next;
    logic       line_start;

    // Next tick begins a new line
    assign line_start = raster.hdump == video_pkg::h_total - 9'd1;

    always_comb begin
        h_next = line_start ? 9'd0 : raster.hdump + 9'd1;
        v_next = raster.vdump;
        if (line_start) begin
            if (raster.vdump == video_pkg::v_total - 9'd1) begin
                v_next = 9'd0;
            end else begin
                v_next = raster.vdump + 9'd1;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            raster <= '0;
            hsync  <= 1'b0;
            vsync  <= 1'b0;
        end else if (pxl_cen) begin
            raster.hdump  <= h_next;
            raster.vdump  <= v_next;
            raster.hblank <= h_next >= video_pkg::h_visible;
            raster.vblank <= v_next >= video_pkg::v_visible;
            hsync <= h_next >= video_pkg::hs_start && h_next < video_pkg::hs_end;
            vsync <= v_next >= video_pkg::vs_start && v_next < video_pkg::vs_end;
        end
    end

endmodule

/* source/video_top.sv */
/*
 * Top level of the tile video subsystem. Connects the raster timing,
 * CPU registers, two scroll layers, the priority mixer and the palette.
 * Tile maps and graphics ROMs are external with asynchronous read.
 */
`timescale 1ns/10ps

module video_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    pxl_cen,
    input  video_pkg::cpu_write_t   cpu,
    output logic [15:0]             mmr_dout,

    output logic [15:0]             map1_addr,
    input  logic [15:0]             map1_data,
    output logic [19:0]             gfx1_addr,
    input  logic [15:0]             gfx1_data,

    output logic [15:0]             map2_addr,
    input  logic [15:0]             map2_data,
    output logic [19:0]             gfx2_addr,
    input  logic [15:0]             gfx2_data,

    output logic [8:0]              hdump,
    output logic [8:0]              vdump,
    output logic                    hsync,
    output logic                    vsync,
    output logic                    lhbl,
    output logic                    lvbl,
    output video_pkg::rgb_t         rgb
);

    video_pkg::raster_t      raster;
    video_pkg::scroll_t      scroll1;
    video_pkg::scroll_t      scroll2;
    video_pkg::layer_ctrl_t  layer_ctrl;
    video_pkg::layer_pxl_t   layer1_pxl;
    video_pkg::layer_pxl_t   layer2_pxl;
    logic [8:0]              pal_index;

    assign hdump = raster.hdump;
    assign vdump = raster.vdump;

    video_timing u_timing (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .pxl_cen    ( pxl_cen    ),
        .raster     ( raster     ),
        .hsync      ( hsync      ),
        .vsync      ( vsync      )
    );

    video_mmr u_mmr (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .cpu        ( cpu        ),
        .mmr_dout   ( mmr_dout   ),
        .scroll1    ( scroll1    ),
        .scroll2    ( scroll2    ),
        .layer_ctrl ( layer_ctrl )
    );

    // 8x8 tiles
    video_layer #( .tile_size(8) ) u_layer1 (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .pxl_cen    ( pxl_cen    ),
        .raster     ( raster     ),
        .scroll     ( scroll1    ),
        .map_addr   ( map1_addr  ),
        .map_data   ( map1_data  ),
        .gfx_addr   ( gfx1_addr  ),
        .gfx_data   ( gfx1_data  ),
        .pxl        ( layer1_pxl )
    );

    // 16x16 tiles
    video_layer #( .tile_size(16) ) u_layer2 (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .pxl_cen    ( pxl_cen    ),
        .raster     ( raster     ),
        .scroll     ( scroll2    ),
        .map_addr   ( map2_addr  ),
        .map_data   ( map2_data  ),
        .gfx_addr   ( gfx2_addr  ),
        .gfx_data   ( gfx2_data  ),
        .pxl        ( layer2_pxl )
    );

    video_colmix u_colmix (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .pxl_cen    ( pxl_cen    ),
        .layer1     ( layer1_pxl ),
        .layer2     ( layer2_pxl ),
        .layer_ctrl ( layer_ctrl ),
        .pal_index  ( pal_index  )
    );

    video_pal u_pal (
        .clk        ( clk           ),
        .rst        ( rst           ),
        .pxl_cen    ( pxl_cen       ),
        .cpu        ( cpu           ),
        .pal_index  ( pal_index     ),
        .hblank     ( raster.hblank ),
        .vblank     ( raster.vblank ),
        .rgb        ( rgb           ),
        .lhbl       ( lhbl          ),
        .lvbl       ( lvbl          )
    );

endmodule
